/* compile.f */
+incdir+logic
logic/arm_core_pkg.sv
logic/control_decoder.sv
logic/operand_unit.sv
logic/execute_unit.sv
logic/arm_core.sv
tests/arm_core_tb.sv

/* Bender.yml */
package:
  name: arm_core

sources:
  - include_dirs:
      - logic
    files:
      - logic/arm_core_pkg.sv
      - logic/control_decoder.sv
      - logic/operand_unit.sv
      - logic/execute_unit.sv
      - logic/arm_core.sv
  - target: test
    include_dirs:
      - logic
    files:
      - tests/arm_core_tb.sv

/* tests/arm_core_tb.sv */
// ARM core testbench
`timescale 1ns/10ps
`include "arm_core_defines.svh"

module arm_core_tb;
    localparam int WB_TIMEOUT = 8;

    logic                   clk;
    logic                   i_reset_n;
    logic                   i_ins_valid;
    logic [`ARM_DATA_W-1:0] i_ins;
    logic                   o_wb_valid;
    logic [`ARM_REG_W-1:0]  o_wb_addr;
    logic [`ARM_DATA_W-1:0] o_wb_data;
    logic [3:0]             o_nzcv;

    logic [31:0] m_regs [16];       // reference register bank
    logic [3:0]  m_nzcv;
    int          cycle;
    int          errors;
    int          seed;
    string       test_name;
    int          exp_edge_q [$];    // strobe edge of each expected write-back
    logic [3:0]  exp_addr_q [$];
    logic [31:0] exp_data_q [$];

    arm_core i_arm_core (.*);

    always #2 clk = ~clk;
    always @(posedge clk) cycle <= cycle + 1;

    task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("Fail %s: expected %h, actual %h", name, exp, act);
            errors++;
        end
    endtask

    // every write-back is matched in order against the model
    always @(negedge clk) begin
        if (o_wb_valid) begin
            if (exp_addr_q.size() == 0) begin
                $display("Error in %s: unexpected write-back to r%0d", test_name, o_wb_addr);
                errors++;
            end else begin
                check_val({test_name, " latency"}, 2, cycle - exp_edge_q.pop_front());
                check_val({test_name, " addr"}, exp_addr_q.pop_front(), o_wb_addr);
                check_val({test_name, " data"}, exp_data_q.pop_front(), o_wb_data);
            end
        end
    end

    function automatic logic [31:0] enc_imm(input logic [3:0] cond, input logic [3:0] op,
            input logic s, input logic [3:0] rn, input logic [3:0] rd, input logic [3:0] rot,
            input logic [7:0] imm8);
        return {cond, 2'b00, 1'b1, op, s, rn, rd, rot, imm8};
    endfunction

    function automatic logic [31:0] enc_reg(input logic [3:0] cond, input logic [3:0] op,
            input logic s, input logic [3:0] rn, input logic [3:0] rd, input logic [4:0] amt,
            input logic [1:0] sh, input logic [3:0] rm);
        return {cond, 2'b00, 1'b0, op, s, rn, rd, amt, sh, 1'b0, rm};
    endfunction

    // one instruction against the model state, called at its strobe edge
    task automatic model_step(input logic [31:0] ins);
        logic [3:0]  op;
        logic [3:0]  nzcv;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] r;
        logic [63:0] uw;
        longint      sw;
        logic        base;
        logic        arith;
        logic        cout;
        logic        sc;
        logic        cb;
        logic [4:0]  amt;
        int          rot;
        op    = ins[24:21];
        nzcv  = m_nzcv;
        arith = 1'b0;
        if (ins[27:26] != 2'b00) begin
            return;     // memory and branch types do nothing
        end
        case (ins[31:29])
            3'd0: base = nzcv[2];                               // EQ
            3'd1: base = nzcv[1];                               // CS
            3'd2: base = nzcv[3];                               // MI
            3'd3: base = nzcv[0];                               // VS
            3'd4: base = nzcv[1] && !nzcv[2];                   // HI
            3'd5: base = (nzcv[3] == nzcv[0]);                  // GE
            3'd6: base = !nzcv[2] && (nzcv[3] == nzcv[0]);      // GT
            default: base = 1'b1;                               // AL
        endcase
        if (base == ins[28]) begin
            return;     // odd codes are the inverse of the even ones
        end
        a = m_regs[ins[19:16]];
        if (ins[25]) begin
            rot = 2 * ins[11:8];
            b   = {24'd0, ins[7:0]};
            if (rot != 0) begin
                b = (b >> rot) | (b << (32 - rot));
            end
            sc = (rot == 0) ? nzcv[1] : b[31];
        end else begin
            b   = m_regs[ins[3:0]];
            amt = ins[11:7];
            sc  = nzcv[1];
            if (amt != 0) begin
                sc = (ins[6:5] == 2'd0) ? b[32 - amt] : b[amt - 1];   // last bit out
                case (ins[6:5])
                    2'd0: b = b << amt;
                    2'd1: b = b >> amt;
                    2'd2: b = $signed(b) >>> amt;
                    default: b = (b >> amt) | (b << (32 - amt));
                endcase
            end
        end
        case (op)
            4'b0100, 4'b0101: begin     // ADD, ADC
                arith = 1'b1;
                cb    = (op == 4'b0101) && nzcv[1];
                uw    = {32'd0, a} + {32'd0, b} + cb;
                sw    = longint'($signed(a)) + longint'($signed(b)) + cb;
                r     = uw[31:0];
                cout  = uw[32];
            end
            4'b0010, 4'b1010, 4'b0110: begin    // SUB, CMP, SBC
                arith = 1'b1;
                cb    = (op == 4'b0110) && !nzcv[1];
                r     = a - b - cb;
                cout  = ({32'd0, a} >= {32'd0, b} + cb);    // no borrow
                sw    = longint'($signed(a)) - longint'($signed(b)) - cb;
            end
            4'b0000, 4'b1000: r = a & b;
            4'b0001: r = a ^ b;
            4'b1100: r = a | b;
            4'b1101: r = b;
            4'b1111: r = ~b;
            default: return;
        endcase
        if (arith) begin
            nzcv = {r[31], r == 32'd0, cout, sw != longint'($signed(r))};
        end else begin
            nzcv = {r[31], r == 32'd0, sc, nzcv[0]};
        end
        if (ins[20] || op == 4'b1000 || op == 4'b1010) begin
            m_nzcv = nzcv;
        end
        if (op != 4'b1000 && op != 4'b1010) begin
            m_regs[ins[15:12]] = r;
            exp_edge_q.push_back(cycle + 1);
            exp_addr_q.push_back(ins[15:12]);
            exp_data_q.push_back(r);
        end
    endtask

    task automatic send(input logic [31:0] ins);
        @(posedge clk);
        i_ins       <= ins;
        i_ins_valid <= 1'b1;
        model_step(ins);
    endtask

    task automatic end_issue();
        @(posedge clk);
        i_ins_valid <= 1'b0;
    endtask

    // wait until every expected write-back is seen, then let stray ones show up
    task automatic collect();
        int waits;
        waits = 0;
        while (exp_addr_q.size() > 0 && waits < WB_TIMEOUT) begin
            @(posedge clk);
            waits++;
        end
        if (exp_addr_q.size() > 0) begin
            $display("Error in %s: no write-back arrived within %0d cycles",
                     test_name, WB_TIMEOUT);
            $display("errors: %0d", errors);
            $display("Simulation failed");
            $finish;
        end else begin
            waits = 0;
            while (waits < 3) begin
                @(posedge clk);
                waits++;
            end
            @(negedge clk);
            check_val({test_name, " nzcv"}, m_nzcv, o_nzcv);
        end
    endtask

    task automatic issue_one(input logic [31:0] ins, input string name);
        test_name = name;
        send(ins);
        end_issue();
        collect();
    endtask

    // full 32-bit value from MOV and three ORRs, issued back to back
    task automatic load_reg(input logic [3:0] rd, input logic [31:0] val);
        test_name = "load_reg";
        send(enc_imm(arm_core_pkg::AL, arm_core_pkg::MOV, 1'b0, 4'd0, rd, 4'd0, val[7:0]));
        send(enc_imm(arm_core_pkg::AL, arm_core_pkg::ORR, 1'b0, rd, rd, 4'd12, val[15:8]));
        send(enc_imm(arm_core_pkg::AL, arm_core_pkg::ORR, 1'b0, rd, rd, 4'd8, val[23:16]));
        send(enc_imm(arm_core_pkg::AL, arm_core_pkg::ORR, 1'b0, rd, rd, 4'd4, val[31:24]));
        end_issue();
        collect();
    endtask

    task automatic mov_immediates();
        for (int i = 0; i < 8; i++) begin
            issue_one(enc_imm(arm_core_pkg::AL, arm_core_pkg::MOV, 1'b0, 4'd0, 4'(i),
                              4'(i * 3), 8'($random(seed))), "mov_imm");
        end
        issue_one(enc_imm(arm_core_pkg::AL, arm_core_pkg::MOV, 1'b0, 4'd0, 4'd9, 4'd1, 8'hc3),
                  "mov_imm ror2");
        check_val("mov_imm ror2 value", 32'hc000_0030, o_wb_data);
    endtask

    task automatic alu_opcodes();
        logic [3:0] ops [6];
        ops = '{arm_core_pkg::ADD, arm_core_pkg::SUB, arm_core_pkg::AND,
                arm_core_pkg::ORR, arm_core_pkg::EOR, arm_core_pkg::MVN};
        for (int r = 0; r < 8; r++) begin
            load_reg(4'(r), $random(seed));
        end
        for (int k = 0; k < 6; k++) begin
            for (int sh = 0; sh < 4; sh++) begin
                issue_one(enc_reg(arm_core_pkg::AL, ops[k], 1'($random(seed)), 4'($random(seed)),
                                  4'(8 + k), 5'($random(seed)), 2'(sh), 4'($random(seed))),
                          $sformatf("alu op %0d shift %0d", k, sh));
            end
        end
    endtask

    task automatic flag_updates();
        load_reg(4'd1, 32'h7fff_ffff);
        load_reg(4'd2, 32'h0000_0001);
        load_reg(4'd3, 32'hffff_ffff);
        load_reg(4'd4, 32'h8000_0000);
        issue_one(enc_reg(arm_core_pkg::AL, arm_core_pkg::CMP, 1'b0, 4'd1, 4'd0, 5'd0, 2'd0, 4'd2),
                  "cmp");
        issue_one(enc_reg(arm_core_pkg::AL, arm_core_pkg::TST, 1'b0, 4'd3, 4'd0, 5'd0, 2'd0, 4'd4),
                  "tst");
        issue_one(enc_reg(arm_core_pkg::AL, arm_core_pkg::ADD, 1'b1, 4'd1, 4'd5, 5'd0, 2'd0, 4'd2),
                  "adds overflow");
        check_val("adds overflow flags", 4'b1001, o_nzcv);
        issue_one(enc_reg(arm_core_pkg::AL, arm_core_pkg::ADD, 1'b1, 4'd3, 4'd5, 5'd0, 2'd0, 4'd2),
                  "adds carry");
        check_val("adds carry flags", 4'b0110, o_nzcv);
        issue_one(enc_reg(arm_core_pkg::AL, arm_core_pkg::ADC, 1'b1, 4'd2, 4'd6, 5'd0, 2'd0, 4'd2),
                  "adc");
        issue_one(enc_reg(arm_core_pkg::AL, arm_core_pkg::SUB, 1'b1, 4'd4, 4'd5, 5'd0, 2'd0, 4'd2),
                  "subs overflow");
        issue_one(enc_reg(arm_core_pkg::AL, arm_core_pkg::SUB, 1'b1, 4'd2, 4'd5, 5'd0, 2'd0, 4'd1),
                  "subs borrow");
        issue_one(enc_reg(arm_core_pkg::AL, arm_core_pkg::SBC, 1'b1, 4'd2, 4'd6, 5'd0, 2'd0, 4'd2),
                  "sbc");
    endtask

    // equal, unsigned lower and signed overflow compares
    task automatic condition_codes();
        logic [3:0] rn_sel [3];
        logic [3:0] rm_sel [3];
        rn_sel = '{4'd1, 4'd2, 4'd4};
        rm_sel = '{4'd1, 4'd1, 4'd2};
        load_reg(4'd1, 32'h7fff_ffff);
        load_reg(4'd2, 32'h0000_0001);
        load_reg(4'd4, 32'h8000_0000);
        for (int s = 0; s < 3; s++) begin
            issue_one(enc_reg(arm_core_pkg::AL, arm_core_pkg::CMP, 1'b0, rn_sel[s], 4'd0, 5'd0,
                              2'd0, rm_sel[s]), "cond cmp");
            for (int cc = 0; cc < 16; cc++) begin
                issue_one(enc_imm(4'(cc), arm_core_pkg::MOV, 1'b0, 4'd0, 4'd7, 4'd0,
                                  8'(cc + 16 * s)), $sformatf("cond %0d setup %0d", cc, s));
            end
        end
    endtask

    task automatic back_to_back_issue();
        test_name = "back_to_back";
        send(enc_imm(arm_core_pkg::AL, arm_core_pkg::MOV, 1'b0, 4'd0, 4'd1, 4'd0, 8'd5));
        send(enc_reg(arm_core_pkg::AL, arm_core_pkg::ADD, 1'b0, 4'd1, 4'd2, 5'd0, 2'd0, 4'd1));
        send(enc_reg(arm_core_pkg::AL, arm_core_pkg::ADD, 1'b1, 4'd2, 4'd3, 5'd2, 2'd0, 4'd1));
        send(enc_reg(arm_core_pkg::AL, arm_core_pkg::SUB, 1'b1, 4'd3, 4'd3, 5'd0, 2'd0, 4'd3));
        send({4'he, 2'b01, 26'h3ff_ffff});     // memory type
        send({4'he, 2'b10, 26'h155_5555});     // branch type
        end_issue();
        collect();
    endtask

    initial begin
        seed        = 32'hcbc2;
        clk         = 1'b0;
        cycle       = 0;
        errors      = 0;
        i_reset_n   = 1'b1;
        i_ins_valid = 1'b0;
        i_ins       = '0;
        m_nzcv      = 4'b0000;
        for (int i = 0; i < 16; i++) begin
            m_regs[i] = 32'd0;
        end
        repeat (2) @(posedge clk);
        i_reset_n <= 1'b0;
        mov_immediates();
        alu_opcodes();
        flag_updates();
        condition_codes();
        back_to_back_issue();
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* logic/arm_core.sv */
// ARM data-processing core
`timescale 1ns/10ps
`include "arm_core_defines.svh"

module arm_core (
    input  logic                   clk,
    input  logic                   i_reset_n,
    input  logic                   i_ins_valid,
    input  logic [`ARM_DATA_W-1:0] i_ins,
    output logic                   o_wb_valid,
    output logic [`ARM_REG_W-1:0]  o_wb_addr,
    output logic [`ARM_DATA_W-1:0] o_wb_data,
    output logic [3:0]             o_nzcv
);
    // stage one to stage two
    logic                   ctl_valid;
    arm_core_pkg::alu_op_e  ctl_op;
    arm_core_pkg::cond_e    ctl_cond;
    logic                   ctl_set_flags;
    logic                   ctl_wb_en;
    logic [`ARM_REG_W-1:0]  ctl_rd;
    logic [`ARM_DATA_W-1:0] opnd_a;
    logic [`ARM_DATA_W-1:0] opnd_b;
    logic                   opnd_shift_c;

    control_decoder u_control_decoder (
        .clk         (clk),
        .i_reset_n   (i_reset_n),
        .i_ins_valid (i_ins_valid),
        .i_ins       (i_ins),
        .o_valid     (ctl_valid),
        .o_op        (ctl_op),
        .o_cond      (ctl_cond),
        .o_set_flags (ctl_set_flags),
        .o_wb_en     (ctl_wb_en),
        .o_rd        (ctl_rd)
    );

    operand_unit u_operand_unit (
        .clk         (clk),
        .i_reset_n   (i_reset_n),
        .i_ins_valid (i_ins_valid),
        .i_ins       (i_ins),
        .i_wb_valid  (o_wb_valid),      // bank written from the write-back port
        .i_wb_addr   (o_wb_addr),
        .i_wb_data   (o_wb_data),
        .i_carry     (o_nzcv[1]),
        .o_opnd_a    (opnd_a),
        .o_opnd_b    (opnd_b),
        .o_shift_c   (opnd_shift_c)
    );

    execute_unit u_execute_unit (
        .clk         (clk),
        .i_reset_n   (i_reset_n),
        .i_valid     (ctl_valid),
        .i_op        (ctl_op),
        .i_cond      (ctl_cond),
        .i_set_flags (ctl_set_flags),
        .i_wb_en     (ctl_wb_en),
        .i_rd        (ctl_rd),
        .i_opnd_a    (opnd_a),
        .i_opnd_b    (opnd_b),
        .i_shift_c   (opnd_shift_c),
        .o_wb_valid  (o_wb_valid),
        .o_wb_addr   (o_wb_addr),
        .o_wb_data   (o_wb_data),
        .o_nzcv      (o_nzcv)
    );

endmodule

/* logic/execute_unit.sv */
// Stage-two execute unit
`timescale 1ns/10ps
`include "arm_core_defines.svh"

module execute_unit (
    input  logic                   clk,
    input  logic                   i_reset_n,
    input  logic                   i_valid,
    input  arm_core_pkg::alu_op_e  i_op,
    input  arm_core_pkg::cond_e    i_cond,
    input  logic                   i_set_flags,
    input  logic                   i_wb_en,
    input  logic [`ARM_REG_W-1:0]  i_rd,
    input  logic [`ARM_DATA_W-1:0] i_opnd_a,
    input  logic [`ARM_DATA_W-1:0] i_opnd_b,
    input  logic                   i_shift_c,
    output logic                   o_wb_valid,
    output logic [`ARM_REG_W-1:0]  o_wb_addr,
    output logic [`ARM_DATA_W-1:0] o_wb_data,
    output logic [3:0]             o_nzcv
);
    logic                   n_flag;
    logic                   z_flag;
    logic                   c_flag;
    logic                   v_flag;
    logic                   cond_pass;
    logic                   exec;
    logic                   is_arith;
    logic                   carry_in;
    logic [`ARM_DATA_W-1:0] alu_y;
    logic [`ARM_DATA_W:0]   sum;
    logic [`ARM_DATA_W-1:0] logic_res;
    logic [`ARM_DATA_W-1:0] alu_res;
    logic                   alu_c;
    logic                   alu_v;
    logic [3:0]             nzcv_next;

    assign {n_flag, z_flag, c_flag, v_flag} = o_nzcv;

    // condition check against current flags
    always_comb begin
        case (i_cond)
            arm_core_pkg::EQ: cond_pass = z_flag;
            arm_core_pkg::NE: cond_pass = !z_flag;
            arm_core_pkg::CS: cond_pass = c_flag;
            arm_core_pkg::CC: cond_pass = !c_flag;
            arm_core_pkg::MI: cond_pass = n_flag;
            arm_core_pkg::PL: cond_pass = !n_flag;
            arm_core_pkg::VS: cond_pass = v_flag;
            arm_core_pkg::VC: cond_pass = !v_flag;
            arm_core_pkg::HI: cond_pass = c_flag && !z_flag;
            arm_core_pkg::LS: cond_pass = !c_flag || z_flag;
            arm_core_pkg::GE: cond_pass = (n_flag == v_flag);
            arm_core_pkg::LT: cond_pass = (n_flag != v_flag);
            arm_core_pkg::GT: cond_pass = !z_flag && (n_flag == v_flag);
            arm_core_pkg::LE: cond_pass = z_flag || (n_flag != v_flag);
            arm_core_pkg::AL: cond_pass = 1'b1;
            default:          cond_pass = 1'b0;     // NV
        endcase
    end

    assign exec = i_valid && cond_pass;

    // adder input select, subtraction is a + ~b + 1
    always_comb begin
        is_arith = 1'b1;
        alu_y    = i_opnd_b;
        carry_in = 1'b0;
        case (i_op)
            arm_core_pkg::ADD: carry_in = 1'b0;
            arm_core_pkg::ADC: carry_in = c_flag;
            arm_core_pkg::SUB,
            arm_core_pkg::CMP: begin
                alu_y    = ~i_opnd_b;
                carry_in = 1'b1;
            end
            arm_core_pkg::SBC: begin
                alu_y    = ~i_opnd_b;
                carry_in = c_flag;      // borrow is not c
            end
            default: is_arith = 1'b0;
        endcase
    end

    assign sum = {1'b0, i_opnd_a} + {1'b0, alu_y} + {{`ARM_DATA_W{1'b0}}, carry_in};

    // logical ops
    always_comb begin
        case (i_op)
            arm_core_pkg::AND,
            arm_core_pkg::TST: logic_res = i_opnd_a & i_opnd_b;
            arm_core_pkg::EOR: logic_res = i_opnd_a ^ i_opnd_b;
            arm_core_pkg::ORR: logic_res = i_opnd_a | i_opnd_b;
            arm_core_pkg::MVN: logic_res = ~i_opnd_b;
            default:           logic_res = i_opnd_b;    // MOV ignores rn
        endcase
    end

    assign alu_res = is_arith ? sum[`ARM_DATA_W-1:0] : logic_res;
    assign alu_c   = is_arith ? sum[`ARM_DATA_W] : i_shift_c;

    // overflow when adder inputs agree in sign and the result differs
    assign alu_v = is_arith ?
                   ((i_opnd_a[`ARM_DATA_W-1] == alu_y[`ARM_DATA_W-1]) &&
                    (sum[`ARM_DATA_W-1] != i_opnd_a[`ARM_DATA_W-1])) :
                   v_flag;      // logical ops keep v

    assign nzcv_next = {alu_res[`ARM_DATA_W-1], (alu_res == '0), alu_c, alu_v};

    always_ff @(posedge clk or posedge i_reset_n) begin
        if (i_reset_n) begin
            o_wb_valid <= 1'b0;
            o_nzcv     <= 4'b0000;
        end else begin
            o_wb_valid <= exec && i_wb_en;
            if (exec && i_set_flags) begin
                o_nzcv <= nzcv_next;
            end
        end
    end

    // write-back payload
    always_ff @(posedge clk) begin
        if (exec && i_wb_en) begin
            o_wb_addr <= i_rd;
            o_wb_data <= alu_res;
        end
    end

endmodule

/* logic/operand_unit.sv */
// Operand fetch and shifter
`timescale 1ns/10ps
`include "arm_core_defines.svh"

module operand_unit (
    input  logic                   clk,
    input  logic                   i_reset_n,
    input  logic                   i_ins_valid,
    input  logic [`ARM_DATA_W-1:0] i_ins,
    input  logic                   i_wb_valid,
    input  logic [`ARM_REG_W-1:0]  i_wb_addr,
    input  logic [`ARM_DATA_W-1:0] i_wb_data,
    input  logic                   i_carry,
    output logic [`ARM_DATA_W-1:0] o_opnd_a,
    output logic [`ARM_DATA_W-1:0] o_opnd_b,
    output logic                   o_shift_c
);
    logic [`ARM_DATA_W-1:0]   regs [`ARM_REG_CNT];
    logic [`ARM_REG_W-1:0]    rn_q;
    logic [`ARM_REG_W-1:0]    rm_q;
    logic [11:0]              imm12_q;
    logic                     imm_q;
    logic [`ARM_DATA_W-1:0]   rm_val;
    logic [4:0]               shift_amt;
    arm_core_pkg::shift_e     shift_type;
    logic [4:0]               rot_amt;
    logic [`ARM_DATA_W-1:0]   imm_wide;
    logic [2*`ARM_DATA_W-1:0] imm_rot;
    logic [`ARM_DATA_W:0]     lsl_x;
    logic [`ARM_DATA_W:0]     lsr_x;
    logic [`ARM_DATA_W:0]     asr_x;
    logic [2*`ARM_DATA_W-1:0] ror_x;

    // operand fields captured with the strobe
    always_ff @(posedge clk) begin
        if (i_ins_valid) begin
            rn_q    <= i_ins[`ARM_RN_MSB -: `ARM_REG_W];
            rm_q    <= i_ins[`ARM_RM_MSB -: `ARM_REG_W];
            imm12_q <= i_ins[11:0];
            imm_q   <= i_ins[`ARM_IMM_BIT];
        end
    end

    // register bank
    always_ff @(posedge clk or posedge i_reset_n) begin
        if (i_reset_n) begin
            for (int i = 0; i < `ARM_REG_CNT; i++) begin
                regs[i] <= '0;
            end
        end else if (i_wb_valid) begin
            regs[i_wb_addr] <= i_wb_data;
        end
    end

    // write-back of the previous instruction is visible to the read
    assign o_opnd_a = (i_wb_valid && i_wb_addr == rn_q) ? i_wb_data : regs[rn_q];
    assign rm_val   = (i_wb_valid && i_wb_addr == rm_q) ? i_wb_data : regs[rm_q];

    assign shift_amt  = imm12_q[11:7];
    assign shift_type = arm_core_pkg::shift_e'(imm12_q[6:5]);
    assign rot_amt    = {imm12_q[11:8], 1'b0};   // rotate right by twice rot4
    assign imm_wide   = {{(`ARM_DATA_W-8){1'b0}}, imm12_q[7:0]};
    assign imm_rot    = {imm_wide, imm_wide} >> rot_amt;

    // extra bit on each side catches the last bit shifted out
    assign lsl_x = {1'b0, rm_val} << shift_amt;
    assign lsr_x = {rm_val, 1'b0} >> shift_amt;
    assign asr_x = $signed({rm_val, 1'b0}) >>> shift_amt;
    assign ror_x = {rm_val, rm_val} >> shift_amt;

    always_comb begin
        if (imm_q) begin
            o_opnd_b  = imm_rot[`ARM_DATA_W-1:0];
            o_shift_c = (rot_amt == 5'd0) ? i_carry : imm_rot[`ARM_DATA_W-1];
        end else if (shift_amt == 5'd0) begin
            o_opnd_b  = rm_val;     // no shift, carry unchanged
            o_shift_c = i_carry;
        end else begin
            case (shift_type)
                arm_core_pkg::LSL: begin
                    o_opnd_b  = lsl_x[`ARM_DATA_W-1:0];
                    o_shift_c = lsl_x[`ARM_DATA_W];
                end
                arm_core_pkg::LSR: begin
                    o_opnd_b  = lsr_x[`ARM_DATA_W:1];
                    o_shift_c = lsr_x[0];
                end
                arm_core_pkg::ASR: begin
                    o_opnd_b  = asr_x[`ARM_DATA_W:1];
                    o_shift_c = asr_x[0];
                end
                default: begin
                    o_opnd_b  = ror_x[`ARM_DATA_W-1:0];
                    o_shift_c = ror_x[`ARM_DATA_W-1];   // last bit rotated out
                end
            endcase
        end
    end

endmodule

/* logic/control_decoder.sv */
// Stage-one control decoder
`timescale 1ns/10ps
`include "arm_core_defines.svh"

module control_decoder (
    input  logic                   clk,
    input  logic                   i_reset_n,
    input  logic                   i_ins_valid,
    input  logic [`ARM_DATA_W-1:0] i_ins,
    output logic                   o_valid,
    output arm_core_pkg::alu_op_e  o_op,
    output arm_core_pkg::cond_e    o_cond,
    output logic                   o_set_flags,
    output logic                   o_wb_en,
    output logic [`ARM_REG_W-1:0]  o_rd
);
    arm_core_pkg::ins_type_e ins_type;
    arm_core_pkg::alu_op_e   op_next;
    logic                    op_known;
    logic                    is_data;
    logic                    is_compare;

    assign ins_type = arm_core_pkg::ins_type_e'(i_ins[`ARM_TYPE_MSB -: 2]);
    assign is_data  = (ins_type == arm_core_pkg::DATA);

    // opcode field to alu op
    always_comb begin
        op_known = 1'b1;
        case (i_ins[`ARM_OP_MSB -: 4])
            4'b0000: op_next = arm_core_pkg::AND;
            4'b0001: op_next = arm_core_pkg::EOR;
            4'b0010: op_next = arm_core_pkg::SUB;
            4'b0100: op_next = arm_core_pkg::ADD;
            4'b0101: op_next = arm_core_pkg::ADC;
            4'b0110: op_next = arm_core_pkg::SBC;
            4'b1000: op_next = arm_core_pkg::TST;
            4'b1010: op_next = arm_core_pkg::CMP;
            4'b1100: op_next = arm_core_pkg::ORR;
            4'b1101: op_next = arm_core_pkg::MOV;
            4'b1111: op_next = arm_core_pkg::MVN;
            default: begin
                // RSB, RSC, TEQ, CMN, BIC run as a no-op
                op_next  = arm_core_pkg::MOV;
                op_known = 1'b0;
            end
        endcase
    end

    assign is_compare = (op_next == arm_core_pkg::TST) || (op_next == arm_core_pkg::CMP);

    // control state
    always_ff @(posedge clk or posedge i_reset_n) begin
        if (i_reset_n) begin
            o_valid     <= 1'b0;
            o_set_flags <= 1'b0;
            o_wb_en     <= 1'b0;
        end else begin
            o_valid <= i_ins_valid;     // non-data types still pass through
            if (i_ins_valid) begin
                o_set_flags <= is_data && op_known && (i_ins[`ARM_S_BIT] || is_compare);
                o_wb_en     <= is_data && op_known && !is_compare;
            end
        end
    end

    // instruction payload
    always_ff @(posedge clk) begin
        if (i_ins_valid) begin
            o_op   <= op_next;
            o_cond <= arm_core_pkg::cond_e'(i_ins[`ARM_COND_MSB -: 4]);
            o_rd   <= i_ins[`ARM_RD_MSB -: `ARM_REG_W];
        end
    end

endmodule

/* logic/arm_core_pkg.sv */
// ARM core types
package arm_core_pkg;

    // data-processing opcodes, values are the ARM encodings
    typedef enum logic [3:0] {
        AND = 4'b0000,
        EOR = 4'b0001,
        SUB = 4'b0010,
        ADD = 4'b0100,
        ADC = 4'b0101,
        SBC = 4'b0110,
        TST = 4'b1000,
        CMP = 4'b1010,
        ORR = 4'b1100,
        MOV = 4'b1101,
        MVN = 4'b1111
    } alu_op_e;

    typedef enum logic [1:0] {
        LSL = 2'b00,
        LSR = 2'b01,
        ASR = 2'b10,
        ROR = 2'b11
    } shift_e;

    typedef enum logic [3:0] {
        EQ = 4'b0000,       // z
        NE = 4'b0001,
        CS = 4'b0010,       // c
        CC = 4'b0011,
        MI = 4'b0100,       // n
        PL = 4'b0101,
        VS = 4'b0110,       // v
        VC = 4'b0111,
        HI = 4'b1000,       // c and not z
        LS = 4'b1001,
        GE = 4'b1010,       // n == v
        LT = 4'b1011,
        GT = 4'b1100,
        LE = 4'b1101,
        AL = 4'b1110,
        NV = 4'b1111
    } cond_e;

    typedef enum logic [1:0] {
        DATA   = 2'b00,
        MEM    = 2'b01,
        BRANCH = 2'b10,
        OTHER  = 2'b11
    } ins_type_e;

endpackage

/* logic/arm_core_defines.svh */
// ARM core parameters
`ifndef ARM_CORE_DEFINES_SVH
`define ARM_CORE_DEFINES_SVH

// datapath and register bank
`define ARM_DATA_W   32
`define ARM_REG_CNT  16
`define ARM_REG_W    4

// instruction field positions (msb of each field)
`define ARM_COND_MSB 31     // cond[31:28]
`define ARM_TYPE_MSB 27     // type[27:26]
`define ARM_IMM_BIT  25     // 1 = rotated immediate
`define ARM_OP_MSB   24     // opcode[24:21]
`define ARM_S_BIT    20     // set flags
`define ARM_RN_MSB   19     // rn[19:16]
`define ARM_RD_MSB   15     // rd[15:12]
`define ARM_RM_MSB   3      // rm[3:0]

// operand two sub-fields sit below rd
// register form is shift_imm[11:7], shift[6:5]
// immediate form is rotate[11:8], imm8[7:0]

`endif
